//--- flist.f
hdl/link_stats_pkg.sv
hdl/frame_classifier.sv
hdl/link_reg_bank.sv
hdl/link_stats_top.sv
bench/link_stats_checker.sv
bench/link_stats_tb.sv

//--- bench/link_stats_tb.sv
// link statistics testbench
// random events, frames and APB transfers against the register bank

`timescale 1ns/10ps
`default_nettype none

module link_stats_tb
  import link_stats_pkg::*;
();

  localparam logic [REGD_BITS-1:0] VERSION = 32'h0001_0300;
  // tests take about 1200 cycles
  localparam int MAX_CYCLES = 5000;

  logic                 clk;
  logic                 rst;
  rx_frame_t            rx_frame;
  tx_events_t           tx_events;
  link_status_t         link_status;
  apb_req_t             apb_req;
  apb_rsp_t             apb_rsp;
  logic [IDLE_BITS-1:0] idle_sentinel_out;
  logic                 test_end;
  logic [3:0]           test_num;
  int                   checks;
  int                   errors;
  int                   cycles = 0;
  int                   seed;
  logic [31:0]          r;

  link_stats_top #(
    .VERSION (VERSION)
  ) dut (
    .clk               (clk),
    .rst               (rst),
    .rx_frame          (rx_frame),
    .tx_events         (tx_events),
    .link_status       (link_status),
    .apb_req           (apb_req),
    .apb_rsp           (apb_rsp),
    .idle_sentinel_out (idle_sentinel_out)
  );

  link_stats_checker #(
    .VERSION (VERSION)
  ) chk (
    .clk               (clk),
    .rst               (rst),
    .rx_frame          (rx_frame),
    .tx_events         (tx_events),
    .link_status       (link_status),
    .apb_req           (apb_req),
    .apb_rsp           (apb_rsp),
    .idle_sentinel_out (idle_sentinel_out),
    .test_end          (test_end),
    .test_num          (test_num),
    .checks            (checks),
    .errors            (errors)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------------
  // inputs change 2 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  // quiet inputs so counts settle before reads
  task automatic settle();
    rx_frame  = '0;
    tx_events = '0;
    tick();
    tick();
  endtask

  // setup, then access until pready
  task automatic apb_xfer(input logic wr, input logic [ADDR_BITS-1:0] addr,
                          input logic [REGD_BITS-1:0] wdata);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    tick();
    apb_req.penable = 1'b1;
    do
    begin
      tick();
    end
    while (!apb_rsp.pready);
    tick();
    apb_req = '0;
  endtask

  task automatic read_reg(input logic [4:0] idx);
    apb_xfer(1'b0, {idx, 2'b00}, '0);
  endtask

  task automatic read_all();
    for (int i = 0; i < 21; i++)
      read_reg(i[4:0]);
  endtask

  // one frame with random header bits
  task automatic send_frame(input logic [3:0] kind, input logic crc, input logic sync);
    rx_frame.valid         = 1'b1;
    rx_frame.crc_bad       = crc;
    rx_frame.sync_bad      = sync;
    rx_frame.hdr           = $urandom();
    rx_frame.hdr.data.kind = frm_kind_e'(kind);
    tick();
  endtask

  task automatic finish_test(input logic [3:0] n);
    test_num = n;
    test_end = 1'b1;
    tick();
    test_end = 1'b0;
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------
  initial
  begin
    seed        = 18;
    r           = $urandom(seed);
    clk         = 1'b0;
    rst         = 1'b1;
    rx_frame    = '0;
    tx_events   = '0;
    link_status = '0;
    apb_req     = '0;
    test_end    = 1'b0;
    test_num    = '0;
    repeat (3) @(posedge clk);
    #2 rst = 1'b0;
    tick();

    // reset values
    read_all();
    finish_test(4'd1);

    // transmit and dispatcher events
    repeat (300)
    begin
      r         = $urandom();
      tx_events = r[6:0];
      tick();
    end
    settle();
    read_all();
    finish_test(4'd2);

    // frames, kinds 0 and 7 illegal
    repeat (400)
    begin
      r = $urandom();
      send_frame({1'b0, r[2:0]}, r[6:4] == 3'd0, r[9:7] == 3'd0);
    end
    settle();
    read_all();
    finish_test(4'd3);

    // remote mask, idle sentinel and live status
    repeat (2)
    begin
      send_frame(4'd5, 1'b0, 1'b0);
      send_frame(4'd6, 1'b0, 1'b0);
      r           = $urandom();
      link_status = r[29:0];
      settle();
      read_all();
    end
    finish_test(4'd4);

    // IDSO write, then a write to a counter
    r = $urandom();
    apb_xfer(1'b1, {IDSO, 2'b00}, r);
    read_reg(IDSO);
    apb_xfer(1'b1, {DFRM, 2'b00}, r);
    read_reg(DFRM);
    finish_test(4'd5);

    // unmapped and misaligned
    for (int i = 21; i < 32; i++)
      read_reg(i[4:0]);
    apb_xfer(1'b0, 7'h01, '0);
    apb_xfer(1'b0, 7'h4a, '0);
    apb_xfer(1'b1, 7'h4d, '1);
    read_reg(IDSO);
    finish_test(4'd6);

    tick();
    $display("summary: %0d transfers checked, %0d errors", checks, errors);
    if (errors == 0 && checks > 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/link_stats_checker.sv
// link statistics checker
// models the counters from the DUT ports and checks every APB response

`timescale 1ns/10ps
`default_nettype none

module link_stats_checker
  import link_stats_pkg::*;
#(
  parameter logic [REGD_BITS-1:0] VERSION = '0
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  rx_frame_t            rx_frame,
  input  tx_events_t           tx_events,
  input  link_status_t         link_status,
  input  apb_req_t             apb_req,
  input  apb_rsp_t             apb_rsp,
  input  logic [IDLE_BITS-1:0] idle_sentinel_out,
  input  logic                 test_end,
  input  logic [3:0]           test_num,
  output int                   checks,
  output int                   errors
);

  // model registers, indexed by register number
  logic [REGD_BITS-1:0] cnt [32];
  logic [NUM_CHANS-1:0] cfcr;
  logic [IDLE_BITS-1:0] idsi;
  logic [IDLE_BITS-1:0] idso;
  logic [3:0]           kind;
  // response expected for the transfer in flight
  logic                 exp_err;
  logic                 exp_wr;
  logic [REGD_BITS-1:0] exp_data;
  // first access cycle seen, pready due next
  logic                 acc_open;
  int                   test_checks;
  int                   test_errors;

  // expected read data and slave error for one access
  function automatic void expected_reg(input logic [4:0] idx, input logic [1:0] lo,
                                       input logic wr, output logic err,
                                       output logic [REGD_BITS-1:0] data);
    err  = (lo != 2'b00) || (idx > 5'd20) || (wr && idx != 5'd19);
    data = '1;
    if (lo == 2'b00 && idx <= 5'd20)
    begin
      case (idx)
        VERS:    data = VERSION;
        CRDT:    data = {26'd0, link_status.crdt};
        EMPT:    data = {24'd0, link_status.empt};
        FULL:    data = {24'd0, link_status.full};
        CFCL:    data = {24'd0, link_status.cfcl};
        CFCR:    data = {24'd0, cfcr};
        IDSO:    data = {16'd0, idso};
        IDSI:    data = {16'd0, idsi};
        default: data = cnt[idx];
      endcase
    end
  endfunction

  task automatic flag_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  // ---------------------------------------------------------------------------
  // reference model of classifier and counters
  // ---------------------------------------------------------------------------
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < 32; i++)
        cnt[i] <= '0;
      cfcr <= '0;
      idsi <= '0;
    end
    else
    begin
      kind = rx_frame.hdr.data.kind;
      if (rx_frame.valid)
      begin
        // crc first, then sync and illegal kind
        if (rx_frame.crc_bad)
          cnt[CRCE] <= cnt[CRCE] + 1;
        else if (rx_frame.sync_bad || kind == 4'd0 || kind > 4'd6)
          cnt[FRME] <= cnt[FRME] + 1;
        else
        begin
          case (kind)
            4'd1:    cnt[DFRM] <= cnt[DFRM] + 1;
            4'd2:    cnt[RACK] <= cnt[RACK] + 1;
            4'd3:    cnt[RNAK] <= cnt[RNAK] + 1;
            4'd4:    cnt[ROOC] <= cnt[ROOC] + 1;
            4'd5:    cfcr <= rx_frame.hdr.ctrl.cfc_mask;
            default: idsi <= rx_frame.hdr.ctrl.idle_snt;
          endcase
        end
      end
      // transmit side
      if (tx_events.sfrm)
        cnt[SFRM] <= cnt[SFRM] + 1;
      if (tx_events.tfrm)
        cnt[TFRM] <= cnt[TFRM] + 1;
      if (tx_events.looc)
        cnt[LOOC] <= cnt[LOOC] + 1;
      if (tx_events.rfrm)
        cnt[RFRM] <= cnt[RFRM] + 1;
      if (tx_events.busy)
        cnt[BUSY] <= cnt[BUSY] + 1;
      if (tx_events.lnak)
        cnt[LNAK] <= cnt[LNAK] + 1;
      if (tx_events.lack)
        cnt[LACK] <= cnt[LACK] + 1;
    end
  end

  // ---------------------------------------------------------------------------
  // APB compare
  // ---------------------------------------------------------------------------
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      idso        = '0;
      exp_err     = 1'b0;
      exp_wr      = 1'b0;
      exp_data    = '0;
      acc_open    = 1'b0;
      checks      = 0;
      errors      = 0;
      test_checks = 0;
      test_errors = 0;
    end
    else
    begin
      if (apb_req.psel && apb_req.penable && !apb_rsp.pready)
      begin
        // one wait state only
        if (acc_open)
          flag_error($sformatf("addr %h: pready low in second access cycle",
                               apb_req.paddr));
        acc_open = 1'b1;
        // first access cycle, response taken from here
        exp_wr = apb_req.pwrite;
        expected_reg(apb_req.paddr[6:2], apb_req.paddr[1:0], exp_wr, exp_err, exp_data);
        if (exp_wr && !exp_err)
          idso = apb_req.pwdata[IDLE_BITS-1:0];
      end
      else if (apb_req.psel && apb_req.penable && apb_rsp.pready)
      begin
        checks++;
        test_checks++;
        if (!acc_open)
          flag_error($sformatf("addr %h: pready high in first access cycle",
                               apb_req.paddr));
        acc_open = 1'b0;
        if (apb_rsp.pslverr !== exp_err)
          flag_error($sformatf("addr %h: pslverr %b, expected %b",
                               apb_req.paddr, apb_rsp.pslverr, exp_err));
        if (!exp_wr && apb_rsp.prdata !== exp_data)
          flag_error($sformatf("addr %h: read %h, expected %h",
                               apb_req.paddr, apb_rsp.prdata, exp_data));
        if (idle_sentinel_out !== idso)
          flag_error($sformatf("idle_sentinel_out %h, expected %h",
                               idle_sentinel_out, idso));
      end
      if (test_end)
      begin
        $display("test %0d finished: %0d transfers, %0d errors",
                 test_num, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/link_stats_top.sv
// link statistics top level
// frame classifier beside the register bank that counts its events

`timescale 1ns/10ps
`default_nettype none

module link_stats_top
  import link_stats_pkg::*;
#(
  // reads back from VERS
  parameter logic [REGD_BITS-1:0] VERSION = 32'h0001_0300
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  rx_frame_t            rx_frame,
  input  tx_events_t           tx_events,
  input  link_status_t         link_status,
  input  apb_req_t             apb_req,
  output apb_rsp_t             apb_rsp,
  output logic [IDLE_BITS-1:0] idle_sentinel_out
);

  // ---------------------------------------------------------------------------
  // classifier to bank
  // ---------------------------------------------------------------------------
  rx_events_t           rx_events;
  logic [NUM_CHANS-1:0] remote_cfc;
  logic [IDLE_BITS-1:0] idle_sentinel_in;

  // header decode, one cycle
  frame_classifier u_classifier (
    .clk              (clk),
    .rst              (rst),
    .rx_frame         (rx_frame),
    .rx_events        (rx_events),
    .remote_cfc       (remote_cfc),
    .idle_sentinel_in (idle_sentinel_in)
  );

  // counters, status and APB slave
  link_reg_bank #(
    .VERSION (VERSION)
  ) u_reg_bank (
    .clk               (clk),
    .rst               (rst),
    .rx_events         (rx_events),
    .tx_events         (tx_events),
    .link_status       (link_status),
    .remote_cfc        (remote_cfc),
    .idle_sentinel_in  (idle_sentinel_in),
    .apb_req           (apb_req),
    .apb_rsp           (apb_rsp),
    .idle_sentinel_out (idle_sentinel_out)
  );

endmodule

`default_nettype wire

//--- hdl/link_reg_bank.sv
// link statistics register bank
// event counters, sampled status and the outgoing idle sentinel,
// read and written over APB with one wait state

`timescale 1ns/10ps
`default_nettype none

module link_reg_bank
  import link_stats_pkg::*;
#(
  parameter logic [REGD_BITS-1:0] VERSION = '0
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  rx_events_t           rx_events,
  input  tx_events_t           tx_events,
  input  link_status_t         link_status,
  input  logic [NUM_CHANS-1:0] remote_cfc,
  input  logic [IDLE_BITS-1:0] idle_sentinel_in,
  input  apb_req_t             apb_req,
  output apb_rsp_t             apb_rsp,
  output logic [IDLE_BITS-1:0] idle_sentinel_out
);

  localparam int NUM_CTRS = 13;

  // counter slots, in register map order
  typedef enum logic [3:0] {
    C_CRCE, C_FRME, C_BUSY, C_LNAK, C_RNAK, C_LACK, C_RACK,
    C_LOOC, C_ROOC, C_SFRM, C_TFRM, C_DFRM, C_RFRM
  } ctr_slot_e;

  logic [NUM_CTRS-1:0]  ev;
  logic [REGD_BITS-1:0] ctr [NUM_CTRS];

  reg_idx_e             idx;
  logic                 bad_align;
  logic                 bad_idx;
  logic                 ro_wr;
  logic                 slv_err;
  logic                 acc_first;
  logic [REGD_BITS-1:0] rd_data;

  // --------------------------------------------------------------------------
  // event counters
  // --------------------------------------------------------------------------
  // receive side, from the classifier
  assign ev[C_CRCE] = rx_events.crce;
  assign ev[C_FRME] = rx_events.frme;
  assign ev[C_RNAK] = rx_events.rnak;
  assign ev[C_RACK] = rx_events.rack;
  assign ev[C_ROOC] = rx_events.rooc;
  assign ev[C_DFRM] = rx_events.dfrm;
  // transmit side and dispatcher
  assign ev[C_BUSY] = tx_events.busy;
  assign ev[C_LNAK] = tx_events.lnak;
  assign ev[C_LACK] = tx_events.lack;
  assign ev[C_LOOC] = tx_events.looc;
  assign ev[C_SFRM] = tx_events.sfrm;
  assign ev[C_TFRM] = tx_events.tfrm;
  assign ev[C_RFRM] = tx_events.rfrm;

  // free-running, wrap at 2^32
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_CTRS; i++)
        ctr[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_CTRS; i++)
      begin
        if (ev[i])
          ctr[i] <= ctr[i] + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // address decode
  // --------------------------------------------------------------------------
  assign idx       = reg_idx_e'(apb_req.paddr[ADDR_BITS-1:2]);
  assign bad_align = (apb_req.paddr[1:0] != 2'b00);
  assign bad_idx   = (idx > IDSI);
  // only IDSO takes writes
  assign ro_wr     = apb_req.pwrite && (idx != IDSO);
  assign slv_err   = bad_align || bad_idx || ro_wr;

  // first access cycle, pready still low
  assign acc_first = apb_req.psel && apb_req.penable && !apb_rsp.pready;

  // read mux, status zero-extended
  always_comb
  begin
    rd_data = '1;
    if (!bad_align)
    begin
      case (idx)
        VERS:    rd_data = VERSION;
        CRCE:    rd_data = ctr[C_CRCE];
        FRME:    rd_data = ctr[C_FRME];
        BUSY:    rd_data = ctr[C_BUSY];
        LNAK:    rd_data = ctr[C_LNAK];
        RNAK:    rd_data = ctr[C_RNAK];
        LACK:    rd_data = ctr[C_LACK];
        RACK:    rd_data = ctr[C_RACK];
        LOOC:    rd_data = ctr[C_LOOC];
        ROOC:    rd_data = ctr[C_ROOC];
        CRDT:    rd_data = REGD_BITS'(link_status.crdt);
        SFRM:    rd_data = ctr[C_SFRM];
        TFRM:    rd_data = ctr[C_TFRM];
        DFRM:    rd_data = ctr[C_DFRM];
        RFRM:    rd_data = ctr[C_RFRM];
        EMPT:    rd_data = REGD_BITS'(link_status.empt);
        FULL:    rd_data = REGD_BITS'(link_status.full);
        CFCL:    rd_data = REGD_BITS'(link_status.cfcl);
        CFCR:    rd_data = REGD_BITS'(remote_cfc);
        IDSO:    rd_data = REGD_BITS'(idle_sentinel_out);
        IDSI:    rd_data = REGD_BITS'(idle_sentinel_in);
        // unmapped index
        default: rd_data = '1;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // APB response
  // --------------------------------------------------------------------------
  // pready rises for exactly one cycle after the first access cycle
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      apb_rsp.pready  <= 1'b0;
      apb_rsp.pslverr <= 1'b0;
      apb_rsp.prdata  <= '0;
    end
    else if (acc_first)
    begin
      apb_rsp.pready  <= 1'b1;
      apb_rsp.pslverr <= slv_err;
      apb_rsp.prdata  <= rd_data;
    end
    else
    begin
      apb_rsp.pready  <= 1'b0;
      apb_rsp.pslverr <= 1'b0;
    end
  end

  // outgoing idle sentinel
  // new value is visible in the pready cycle
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      idle_sentinel_out <= '0;
    else if (acc_first && apb_req.pwrite && !slv_err)
      idle_sentinel_out <= apb_req.pwdata[IDLE_BITS-1:0];
  end

endmodule

`default_nettype wire

//--- hdl/frame_classifier.sv
// received frame classifier
// turns each received header into one registered event pulse
// and keeps the remote flow-control mask and idle sentinel

`timescale 1ns/10ps
`default_nettype none

module frame_classifier
  import link_stats_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  rx_frame_t            rx_frame,
  output rx_events_t           rx_events,
  output logic [NUM_CHANS-1:0] remote_cfc,
  output logic [IDLE_BITS-1:0] idle_sentinel_in
);

  // next-cycle pulses
  rx_events_t ev_d;
  // state loads from control frames
  logic       ld_cfc;
  logic       ld_idle;
  // kind read through the data view
  frm_kind_e  kind;

  assign kind = rx_frame.hdr.data.kind;

  // --------------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------------
  always_comb
  begin
    ev_d    = '0;
    ld_cfc  = 1'b0;
    ld_idle = 1'b0;
    if (rx_frame.valid)
    begin
      // crc error wins over everything
      if (rx_frame.crc_bad)
        ev_d.crce = 1'b1;
      else if (rx_frame.sync_bad)
        ev_d.frme = 1'b1;
      else
      begin
        case (kind)
          DATA:    ev_d.dfrm = 1'b1;
          ACK:     ev_d.rack = 1'b1;
          NAK:     ev_d.rnak = 1'b1;
          OOC:     ev_d.rooc = 1'b1;
          // control frames only update state
          CFC:     ld_cfc  = 1'b1;
          IDLE:    ld_idle = 1'b1;
          // illegal kind counts as a framing error
          default: ev_d.frme = 1'b1;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // registered outputs
  // --------------------------------------------------------------------------
  // one pulse per frame, one cycle later
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      rx_events <= '0;
    else
      rx_events <= ev_d;
  end

  // last mask seen from the far end
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      remote_cfc <= '0;
    else if (ld_cfc)
      remote_cfc <= rx_frame.hdr.ctrl.cfc_mask;
  end

  // last idle sentinel seen from the far end
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      idle_sentinel_in <= '0;
    else if (ld_idle)
      idle_sentinel_in <= rx_frame.hdr.ctrl.idle_snt;
  end

endmodule

`default_nettype wire

//--- hdl/link_stats_pkg.sv
// link statistics shared definitions
// widths, register map, frame header views, event and APB bundles

`default_nettype none

package link_stats_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  localparam int REGD_BITS = 32;
  localparam int NUM_CHANS = 8;
  localparam int CRDT_BITS = 6;
  localparam int IDLE_BITS = 16;
  // byte address, register index in bits 6..2
  localparam int ADDR_BITS = 7;

  // register map, 21..31 unmapped
  typedef enum logic [4:0] {
    VERS = 5'd0,  CRCE = 5'd1,  FRME = 5'd2,  BUSY = 5'd3,  LNAK = 5'd4,
    RNAK = 5'd5,  LACK = 5'd6,  RACK = 5'd7,  LOOC = 5'd8,  ROOC = 5'd9,
    CRDT = 5'd10, SFRM = 5'd11, TFRM = 5'd12, DFRM = 5'd13, RFRM = 5'd14,
    EMPT = 5'd15, FULL = 5'd16, CFCL = 5'd17, CFCR = 5'd18, IDSO = 5'd19,
    IDSI = 5'd20
  } reg_idx_e;

  // frame kinds, anything else is illegal
  typedef enum logic [3:0] {
    DATA = 4'd1, ACK = 4'd2, NAK = 4'd3, OOC = 4'd4, CFC = 4'd5, IDLE = 4'd6
  } frm_kind_e;

  // --------------------------------------------------------------------------
  // received header, one word with two views
  // --------------------------------------------------------------------------
  typedef struct packed {
    frm_kind_e   kind;
    logic [2:0]  chan;
    logic [6:0]  seq;
    logic [1:0]  len;
    logic [15:0] rsvd;
  } data_hdr_t;

  typedef struct packed {
    frm_kind_e              kind;
    logic [NUM_CHANS-1:0]   cfc_mask;
    logic [IDLE_BITS-1:0]   idle_snt;
    logic [3:0]             rsvd;
  } ctrl_hdr_t;

  // kind sits in the top nibble of both views
  typedef union packed {
    data_hdr_t data;
    ctrl_hdr_t ctrl;
  } rx_hdr_u;

  typedef struct packed {
    logic    valid;
    logic    crc_bad;
    logic    sync_bad;
    rx_hdr_u hdr;
  } rx_frame_t;

  // --------------------------------------------------------------------------
  // event pulses and live status
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic dfrm;
    logic crce;
    logic frme;
    logic rnak;
    logic rack;
    logic rooc;
  } rx_events_t;

  typedef struct packed {
    logic sfrm;
    logic tfrm;
    logic looc;
    logic rfrm;
    logic busy;
    logic lnak;
    logic lack;
  } tx_events_t;

  typedef struct packed {
    logic [CRDT_BITS-1:0] crdt;
    logic [NUM_CHANS-1:0] empt;
    logic [NUM_CHANS-1:0] full;
    logic [NUM_CHANS-1:0] cfcl;
  } link_status_t;

  // APB request and response
  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [ADDR_BITS-1:0] paddr;
    logic [REGD_BITS-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [REGD_BITS-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire
